//--- hw/conv_pe_pkg.sv
// Convolution PE shared definitions
// Widths, APB register map, FSM and push encodings, bus structs
`default_nettype none

package conv_pe_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int DATA_W     = 8;                   // One ifmap or filter byte
    localparam int FIFO_DEPTH = 4;                   // Entries per FIFO, one burst word
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;      // Count reaches FIFO_DEPTH
    localparam int ACC_W      = 18;                  // 4 x (-128 * -128) fits
    localparam int APB_AW     = 8;
    localparam int APB_DW     = 32;

    // ========================================
    // APB register map
    // ========================================
    localparam logic [APB_AW-1:0] ADDR_CTRL       = 8'h00; // W: start, len_m1
    localparam logic [APB_AW-1:0] ADDR_IFMAP_BYTE = 8'h04; // W: byte in [7:0]
    localparam logic [APB_AW-1:0] ADDR_IFMAP_WORD = 8'h08; // W: 4 bytes, lane 0 first
    localparam logic [APB_AW-1:0] ADDR_FILT_BYTE  = 8'h0C;
    localparam logic [APB_AW-1:0] ADDR_FILT_WORD  = 8'h10;
    localparam logic [APB_AW-1:0] ADDR_STATUS     = 8'h14; // R, clears drop and done
    localparam logic [APB_AW-1:0] ADDR_RESULT     = 8'h18; // R: acc sign-extended

    localparam int CTRL_START_BIT = 0;  // CTRL[0] start
    localparam int CTRL_LEN_LSB   = 1;  // CTRL[2:1] length minus one

    // STATUS bits: [0] done [1] busy [2] drop [3] ifmap empty [4] ifmap full
    //              [5] filt empty [6] filt full
    localparam int STATUS_W = 7;

    // ========================================
    // Encodings and bundles
    // ========================================
    typedef enum logic {PUSH_BYTE = 1'b0, PUSH_WORD = 1'b1} push_mode_e;
    typedef enum logic [1:0] {IDLE, RUN, DRAIN, DONE} ctrl_state_e;

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

    typedef struct packed {
        logic                         en;
        push_mode_e                   mode;
        logic [DATA_W*FIFO_DEPTH-1:0] data;  // Lane 0 is popped first
    } push_req_t;

    typedef struct packed {logic full; logic empty;} fifo_stat_t;
    typedef struct packed {logic start; logic [1:0] len_m1;} pe_cmd_t;
    typedef struct packed {logic busy; logic done;} pe_stat_t;

endpackage

`default_nettype wire

//--- hw/ifmap_fifo.sv
// Byte FIFO for the PE operands
// Single-byte push, 4-byte burst push into an empty FIFO,
// registered pop data one cycle after the pop
`default_nettype none

module ifmap_fifo (
    input  wire                          clk,
    input  wire                          rst_n,
    input  conv_pe_pkg::push_req_t       push,      // One-cycle push request
    input  wire                          pop,       // Shared pop from the controller
    output logic [conv_pe_pkg::DATA_W-1:0] pop_data, // Valid the cycle after pop
    output conv_pe_pkg::fifo_stat_t      stat
);

    logic [conv_pe_pkg::DATA_W-1:0] mem [conv_pe_pkg::FIFO_DEPTH];
    conv_pe_pkg::fifo_ptr_t wr_ptr;   // Next slot to write
    conv_pe_pkg::fifo_ptr_t rd_ptr;   // Next slot to read
    conv_pe_pkg::fifo_cnt_t count;    // Valid entries

    logic byte_ok;
    logic word_ok;
    logic pop_ok;

    assign stat.full  = (count == conv_pe_pkg::fifo_cnt_t'(conv_pe_pkg::FIFO_DEPTH));
    assign stat.empty = (count == '0);

    // Acceptance rules: byte needs room, burst needs an empty FIFO
    assign byte_ok = push.en && (push.mode == conv_pe_pkg::PUSH_BYTE) && !stat.full;
    assign word_ok = push.en && (push.mode == conv_pe_pkg::PUSH_WORD) && stat.empty;
    assign pop_ok  = pop && !stat.empty;

    // ========================================
    // Pointers and count
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (byte_ok)
                wr_ptr <= wr_ptr + 1'b1;  // Burst wraps a full turn, ptr unchanged
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            if (word_ok) begin
                count <= conv_pe_pkg::fifo_cnt_t'(conv_pe_pkg::FIFO_DEPTH);
            end else begin
                case ({byte_ok, pop_ok})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;        // Idle, or push and pop together
                endcase
            end
        end
    end

    // ========================================
    // Storage
    // ========================================
    // Burst lanes land from rd_ptr onward so lane 0 leaves first
    always_ff @(posedge clk) begin
        if (byte_ok)
            mem[wr_ptr] <= push.data[conv_pe_pkg::DATA_W-1:0];
        else if (word_ok) begin
            for (int i = 0; i < conv_pe_pkg::FIFO_DEPTH; i++) begin
                mem[rd_ptr + conv_pe_pkg::fifo_ptr_t'(i)] <=
                    push.data[i*conv_pe_pkg::DATA_W +: conv_pe_pkg::DATA_W];
            end
        end
    end

    // Output register, holds its value between pops
    always_ff @(posedge clk) begin
        if (pop_ok)
            pop_data <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

//--- hw/pe_mac.sv
// PE multiply-accumulate
// Signed 8x8 product added into an 18-bit accumulator,
// zeroed by clear, updated only on mac_valid
`default_nettype none

module pe_mac (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   clear,      // Start of a new dot product
    input  wire                                   mac_valid,  // Operand bytes are valid
    input  wire   [conv_pe_pkg::DATA_W-1:0]       ifmap_byte,
    input  wire   [conv_pe_pkg::DATA_W-1:0]       filt_byte,
    output logic signed [conv_pe_pkg::ACC_W-1:0]  acc
);

    // ========================================
    // Product
    // ========================================
    logic signed [conv_pe_pkg::DATA_W-1:0]   a_s;
    logic signed [conv_pe_pkg::DATA_W-1:0]   b_s;
    logic signed [2*conv_pe_pkg::DATA_W-1:0] prod;      // 16-bit signed product
    logic signed [conv_pe_pkg::ACC_W-1:0]    prod_ext;  // Sign-extended to acc width

    // Bytes are two's complement
    assign a_s = signed'(ifmap_byte);
    assign b_s = signed'(filt_byte);

    assign prod     = a_s * b_s;   // Range -16256 .. 16384
    assign prod_ext = prod;        // Signed source, sign-extends

    // ========================================
    // Accumulator
    // ========================================
    // Clear wins, a new run never overlaps a valid from the old one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (mac_valid) begin
            acc <= acc + prod_ext;  // No overflow for up to 4 terms
        end
    end

endmodule

`default_nettype wire

//--- hw/pe_ctrl.sv
// PE controller
// Sequences FIFO pops and the MAC for a dot product of 1..4 terms,
// holds under back-pressure, raises done until status is read
`default_nettype none

module pe_ctrl (
    input  wire                       clk,
    input  wire                       rst_n,
    input  conv_pe_pkg::pe_cmd_t      cmd,         // One-cycle start plus length
    input  conv_pe_pkg::fifo_stat_t   ifmap_stat,
    input  conv_pe_pkg::fifo_stat_t   filt_stat,
    input  wire                       status_rd,   // STATUS read, clears done
    output logic                      pop,         // Shared by both FIFOs
    output logic                      clear,       // Zero the accumulator
    output logic                      mac_valid,   // pop delayed one cycle
    output conv_pe_pkg::pe_stat_t     stat
);

    conv_pe_pkg::ctrl_state_e state;
    conv_pe_pkg::ctrl_state_e state_nxt;
    conv_pe_pkg::fifo_cnt_t   rem;      // Pops still to issue
    logic start_ok;
    logic both_avail;
    logic done;

    assign start_ok   = cmd.start && (state == conv_pe_pkg::IDLE);
    assign both_avail = !ifmap_stat.empty && !filt_stat.empty;

    // Pop in lockstep, stall while either side is empty
    assign pop = (state == conv_pe_pkg::RUN) && (rem != '0) && both_avail;

    assign stat.busy = (state != conv_pe_pkg::IDLE);
    assign stat.done = done;

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        state_nxt = state;
        case (state)
            conv_pe_pkg::IDLE:  if (start_ok) state_nxt = conv_pe_pkg::RUN;
            conv_pe_pkg::RUN:   if (pop && (rem == conv_pe_pkg::fifo_cnt_t'(1)))
                                    state_nxt = conv_pe_pkg::DRAIN;  // Last pop issued
            conv_pe_pkg::DRAIN: if (mac_valid) state_nxt = conv_pe_pkg::DONE; // Last add
            conv_pe_pkg::DONE:  state_nxt = conv_pe_pkg::IDLE;
            default:            state_nxt = conv_pe_pkg::IDLE;
        endcase
    end

    // ========================================
    // Registers
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= conv_pe_pkg::IDLE;
            rem       <= '0;
            clear     <= 1'b0;
            mac_valid <= 1'b0;
        end else begin
            state     <= state_nxt;
            clear     <= start_ok;  // Acc zeroed before the first add
            mac_valid <= pop;       // FIFO data is registered one cycle
            if (start_ok)
                rem <= conv_pe_pkg::fifo_cnt_t'(cmd.len_m1) + conv_pe_pkg::fifo_cnt_t'(1);
            else if (pop)
                rem <= rem - 1'b1;
        end
    end

    // Done flag, set leaving DONE, wins over a same-cycle status read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            done <= 1'b0;
        else if (state == conv_pe_pkg::DONE)
            done <= 1'b1;
        else if (status_rd || start_ok)
            done <= 1'b0;  // New run or software acknowledged
    end

endmodule

`default_nettype wire

//--- hw/pe_apb_regs.sv
// PE APB register block
// Decodes pushes, start, status and result; flags bus errors;
// keeps the sticky drop flag for rejected pushes
`default_nettype none

module pe_apb_regs (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire   [conv_pe_pkg::APB_AW-1:0]      paddr,
    input  wire                                  psel,
    input  wire                                  penable,
    input  wire                                  pwrite,
    input  wire   [conv_pe_pkg::APB_DW-1:0]      pwdata,
    output logic  [conv_pe_pkg::APB_DW-1:0]      prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output conv_pe_pkg::push_req_t               ifmap_push,
    output conv_pe_pkg::push_req_t               filt_push,
    input  conv_pe_pkg::fifo_stat_t              ifmap_stat,
    input  conv_pe_pkg::fifo_stat_t              filt_stat,
    output conv_pe_pkg::pe_cmd_t                 cmd,
    input  conv_pe_pkg::pe_stat_t                pe_stat,
    input  wire signed [conv_pe_pkg::ACC_W-1:0]  acc,
    output logic                                 status_rd
);

    logic acc_phase;   // APB access phase
    logic wr_en;
    logic rd_en;
    logic addr_hit;
    logic start_req;
    logic drop;        // Sticky, some push was rejected

    // Push request for one FIFO from its byte and word addresses
    function automatic conv_pe_pkg::push_req_t make_push(
        input logic                           en,
        input logic [conv_pe_pkg::APB_AW-1:0] addr,
        input logic [conv_pe_pkg::APB_DW-1:0] data,
        input logic [conv_pe_pkg::APB_AW-1:0] byte_addr,
        input logic [conv_pe_pkg::APB_AW-1:0] word_addr
    );
        conv_pe_pkg::push_req_t req;
        req.en   = en && ((addr == byte_addr) || (addr == word_addr));
        req.mode = (addr == word_addr) ? conv_pe_pkg::PUSH_WORD : conv_pe_pkg::PUSH_BYTE;
        req.data = data;
        return req;
    endfunction

    // Same acceptance rule as the FIFO, seen from the bus side
    function automatic logic rejected(input conv_pe_pkg::push_req_t req,
                                      input conv_pe_pkg::fifo_stat_t st);
        return req.en && ((req.mode == conv_pe_pkg::PUSH_BYTE) ? st.full : !st.empty);
    endfunction

    assign acc_phase = psel && penable;
    assign wr_en     = acc_phase && pwrite;
    assign rd_en     = acc_phase && !pwrite;
    assign pready    = 1'b1;  // Zero wait states

    always_comb begin
        case (paddr)
            conv_pe_pkg::ADDR_CTRL, conv_pe_pkg::ADDR_IFMAP_BYTE,
            conv_pe_pkg::ADDR_IFMAP_WORD, conv_pe_pkg::ADDR_FILT_BYTE,
            conv_pe_pkg::ADDR_FILT_WORD, conv_pe_pkg::ADDR_STATUS,
            conv_pe_pkg::ADDR_RESULT: addr_hit = 1'b1;
            default:                  addr_hit = 1'b0;
        endcase
    end

    // ========================================
    // Commands and errors
    // ========================================
    assign start_req  = wr_en && (paddr == conv_pe_pkg::ADDR_CTRL) &&
                        pwdata[conv_pe_pkg::CTRL_START_BIT];
    assign cmd.start  = start_req && !pe_stat.busy;  // Start while busy is dropped
    assign cmd.len_m1 = pwdata[conv_pe_pkg::CTRL_LEN_LSB +: 2];
    assign pslverr    = acc_phase && (!addr_hit || (start_req && pe_stat.busy));

    assign ifmap_push = make_push(wr_en, paddr, pwdata,
                                  conv_pe_pkg::ADDR_IFMAP_BYTE, conv_pe_pkg::ADDR_IFMAP_WORD);
    assign filt_push  = make_push(wr_en, paddr, pwdata,
                                  conv_pe_pkg::ADDR_FILT_BYTE, conv_pe_pkg::ADDR_FILT_WORD);
    assign status_rd  = rd_en && (paddr == conv_pe_pkg::ADDR_STATUS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            drop <= 1'b0;
        else if (rejected(ifmap_push, ifmap_stat) || rejected(filt_push, filt_stat))
            drop <= 1'b1;
        else if (status_rd)
            drop <= 1'b0;  // Read returns the old value, then clears
    end

    // Read mux
    always_comb begin
        prdata = '0;
        case (paddr)
            conv_pe_pkg::ADDR_STATUS:
                prdata[conv_pe_pkg::STATUS_W-1:0] = {filt_stat, ifmap_stat, drop, pe_stat};
            conv_pe_pkg::ADDR_RESULT:
                prdata = {{(conv_pe_pkg::APB_DW-conv_pe_pkg::ACC_W){acc[conv_pe_pkg::ACC_W-1]}},
                          acc};
            default: prdata = '0;  // Push and CTRL addresses are write-only
        endcase
    end

endmodule

`default_nettype wire

//--- hw/conv_pe_top.sv
// Convolution PE top
// APB registers, controller, ifmap and filter FIFOs, MAC
`default_nettype none

module conv_pe_top (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire  [conv_pe_pkg::APB_AW-1:0]   paddr,
    input  wire                              psel,
    input  wire                              penable,
    input  wire                              pwrite,
    input  wire  [conv_pe_pkg::APB_DW-1:0]   pwdata,
    output logic [conv_pe_pkg::APB_DW-1:0]   prdata,
    output logic                             pready,
    output logic                             pslverr
);

    conv_pe_pkg::push_req_t  ifmap_push, filt_push;
    conv_pe_pkg::fifo_stat_t ifmap_stat, filt_stat;
    conv_pe_pkg::pe_cmd_t    cmd;
    conv_pe_pkg::pe_stat_t   pe_stat;
    logic                    status_rd;
    logic                    pop, clear, mac_valid;
    logic [conv_pe_pkg::DATA_W-1:0]       ifmap_byte, filt_byte;
    logic signed [conv_pe_pkg::ACC_W-1:0] acc;

    pe_apb_regs u_regs (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .ifmap_push, .filt_push, .ifmap_stat, .filt_stat, .cmd, .pe_stat, .acc, .status_rd
    );

    pe_ctrl u_ctrl (
        .clk, .rst_n, .cmd, .ifmap_stat, .filt_stat, .status_rd,
        .pop, .clear, .mac_valid, .stat(pe_stat)
    );

    // Both FIFOs pop together
    ifmap_fifo u_ifmap_fifo (
        .clk, .rst_n, .push(ifmap_push), .pop, .pop_data(ifmap_byte), .stat(ifmap_stat)
    );
    ifmap_fifo u_filt_fifo (
        .clk, .rst_n, .push(filt_push), .pop, .pop_data(filt_byte), .stat(filt_stat)
    );

    pe_mac u_mac (.clk, .rst_n, .clear, .mac_valid, .ifmap_byte, .filt_byte, .acc);

endmodule

`default_nettype wire

//--- verification/conv_pe_checker.sv
// PE invariant checker, bound into the top level
// FIFO status sanity, pop gating, MAC valid timing, reset state
`default_nettype none

module conv_pe_checker (
    input  wire                      clk,
    input  wire                      rst_n,
    input  conv_pe_pkg::fifo_stat_t  ifmap_stat,
    input  conv_pe_pkg::fifo_stat_t  filt_stat,
    input  wire                      pop,
    input  wire                      mac_valid,
    input  conv_pe_pkg::pe_stat_t    pe_stat
);

    // A FIFO is never full and empty at the same time
    ifmap_stat_ok: assert property (@(posedge clk) disable iff (!rst_n)
        !(ifmap_stat.full && ifmap_stat.empty))
        else $error("ifmap FIFO reports full and empty together");
    filt_stat_ok: assert property (@(posedge clk) disable iff (!rst_n)
        !(filt_stat.full && filt_stat.empty))
        else $error("filter FIFO reports full and empty together");

    pop_gated: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> (!ifmap_stat.empty && !filt_stat.empty))  // Lockstep pop needs both
        else $error("pop raised while a FIFO is empty");

    // MAC sees data exactly one cycle after the pop
    valid_follows_pop: assert property (@(posedge clk) disable iff (!rst_n)
        mac_valid == $past(pop))
        else $error("mac_valid does not follow pop by one cycle");

    idle_after_reset: assert property (@(posedge clk) !rst_n |=> !pe_stat.busy)
        else $error("controller busy right after reset");

endmodule

bind conv_pe_top conv_pe_checker u_checker (
    .clk, .rst_n, .ifmap_stat, .filt_stat, .pop, .mac_valid, .pe_stat
);

`default_nettype wire

//--- verification/conv_pe_tb.sv
// Convolution PE testbench
// APB pushes and starts, result compared against a reference dot product
`default_nettype none

module conv_pe_tb;

    logic        clk;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          errors = 0;
    int          test_errs = 0;           // Error count at the start of a test
    int          cycles = 0;
    int          cycle_limit = 6 * 60;    // 6 tests, about 60 cycles each
    logic        last_err;                // pslverr of the last access
    logic [31:0] rng = 32'd68;
    logic [31:0] rdata;
    logic [31:0] ifm;
    logic [31:0] flt;
    conv_pe_pkg::fifo_stat_t st_empty, st_part, st_full;
    conv_pe_pkg::pe_stat_t   pe_idle, pe_busy;

    conv_pe_top dut (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr
    );

    // ========================================
    // Reference model and helpers
    // ========================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Signed sum over the first len lanes, lane 0 pushed first
    function automatic logic signed [conv_pe_pkg::ACC_W-1:0] ref_dot(
        input logic [31:0] a, input logic [31:0] b, input int len);
        int sum;
        sum = 0;
        for (int i = 0; i < len; i++)
            sum += $signed(a[i*8 +: 8]) * $signed(b[i*8 +: 8]);
        return sum[conv_pe_pkg::ACC_W-1:0];
    endfunction

    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;     // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;     // Access phase, ends at the next edge
        #1;
        data     = prdata;  // Mid-cycle, settled
        last_err = pslverr;
        if (pready !== 1'b1) begin
            $display("[FAIL] pready at 0x%h: expected 1, actual %b", addr, pready);
            errors++;
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        apb_access(1'b1, addr, wdata, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, 32'd0, data);
    endtask

    task automatic start_run(input int len);
        apb_write(conv_pe_pkg::ADDR_CTRL, ((len - 1) << conv_pe_pkg::CTRL_LEN_LSB) | 1);
    endtask

    // n byte pairs, lane 0 first
    task automatic push_pairs(input logic [31:0] a, input logic [31:0] b, input int n);
        for (int i = 0; i < n; i++) begin
            apb_write(conv_pe_pkg::ADDR_IFMAP_BYTE, a >> (8 * i));
            apb_write(conv_pe_pkg::ADDR_FILT_BYTE, b >> (8 * i));
        end
    endtask

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_result(input string name,
                                input logic signed [conv_pe_pkg::ACC_W-1:0] exp,
                                input logic [31:0] act);
        logic [31:0] exp_ext;
        exp_ext = {{(32 - conv_pe_pkg::ACC_W){exp[conv_pe_pkg::ACC_W-1]}}, exp};
        if (act !== exp_ext) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, $signed(exp_ext), $signed(act));
            errors++;
        end
    endtask

    task automatic check_status(input string name, input conv_pe_pkg::pe_stat_t pe,
                                input logic drop, input conv_pe_pkg::fifo_stat_t ifs,
                                input conv_pe_pkg::fifo_stat_t fls, input logic [31:0] act);
        logic [6:0] exp;
        exp = {fls, ifs, drop, pe};  // Filter, ifmap, drop, busy/done
        if (act[6:0] !== exp) begin
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act[6:0]);
            errors++;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected pslverr %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // Poll STATUS until done, then compare RESULT
    task automatic check_run(input string name, input logic [31:0] a,
                             input logic [31:0] b, input int len);
        logic [31:0] st;
        do begin
            apb_read(conv_pe_pkg::ADDR_STATUS, st);
        end while (!st[0]);
        apb_read(conv_pe_pkg::ADDR_RESULT, rdata);
        check_result(name, ref_dot(a, b, len), rdata);
    endtask

    task automatic end_test(input string name);
        $display("Test %s: %s", name, (errors == test_errs) ? "ok" : "failed");
        test_errs = errors;
    endtask

    // ========================================
    // Clock, reset, watchdog
    // ========================================
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("ERRORS FOUND");
        $finish;
    end

    // ========================================
    // Tests
    // ========================================
    initial begin
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        st_empty = 2'b01;  // {full, empty}
        st_part  = 2'b00;
        st_full  = 2'b10;
        pe_idle  = 2'b00;  // {busy, done}
        pe_busy  = 2'b10;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        // 1. Word bursts, len 4
        rng = xorshift32(rng); ifm = rng;
        rng = xorshift32(rng); flt = rng;
        apb_write(conv_pe_pkg::ADDR_IFMAP_WORD, ifm);
        apb_write(conv_pe_pkg::ADDR_FILT_WORD, flt);
        start_run(4);
        check_run("word_len4", ifm, flt, 4);
        apb_read(conv_pe_pkg::ADDR_STATUS, rdata);
        check_status("word_len4_empty", pe_idle, 1'b0, st_empty, st_empty, rdata);
        end_test("word_burst");

        // 2. Byte pushes, len 2 then a fresh len 3
        rng = xorshift32(rng); ifm = rng;
        rng = xorshift32(rng); flt = rng;
        push_pairs(ifm, flt, 2);
        start_run(2);
        check_run("byte_len2", ifm, flt, 2);
        rng = xorshift32(rng); ifm = rng;
        rng = xorshift32(rng); flt = rng;
        push_pairs(ifm, flt, 3);
        start_run(3);
        check_run("byte_len3", ifm, flt, 3);  // Old sum must not carry over
        end_test("byte_push");

        // 3. Word burst into a non-empty FIFO is dropped
        rng = xorshift32(rng); ifm = rng;
        rng = xorshift32(rng); flt = rng;
        apb_write(conv_pe_pkg::ADDR_IFMAP_BYTE, ifm);
        apb_write(conv_pe_pkg::ADDR_IFMAP_WORD, ~ifm);
        apb_read(conv_pe_pkg::ADDR_STATUS, rdata);
        check_status("drop_set", pe_idle, 1'b1, st_part, st_empty, rdata);
        apb_write(conv_pe_pkg::ADDR_FILT_BYTE, flt);
        start_run(1);
        check_run("drop_len1", ifm, flt, 1);
        apb_read(conv_pe_pkg::ADDR_STATUS, rdata);
        check_status("drop_clear", pe_idle, 1'b0, st_empty, st_empty, rdata);
        end_test("drop_word");

        // 4. Fifth byte into a full filter FIFO is dropped
        rng = xorshift32(rng); ifm = rng;
        rng = xorshift32(rng); flt = rng;
        for (int i = 0; i < 4; i++)
            apb_write(conv_pe_pkg::ADDR_FILT_BYTE, flt >> (8 * i));
        apb_write(conv_pe_pkg::ADDR_FILT_BYTE, ~flt);
        apb_read(conv_pe_pkg::ADDR_STATUS, rdata);
        check_status("overflow_set", pe_idle, 1'b1, st_empty, st_full, rdata);
        apb_write(conv_pe_pkg::ADDR_IFMAP_WORD, ifm);
        start_run(4);
        check_run("overflow_kept", ifm, flt, 4);
        end_test("drop_overflow");

        // 5. Start with empty FIFOs, data trickles in
        rng = xorshift32(rng); ifm = rng;
        rng = xorshift32(rng); flt = rng;
        start_run(3);
        apb_read(conv_pe_pkg::ADDR_STATUS, rdata);
        check_status("stall_busy", pe_busy, 1'b0, st_empty, st_empty, rdata);
        push_pairs(ifm, flt, 3);
        check_run("stall_len3", ifm, flt, 3);
        end_test("back_pressure");

        // 6. Unmapped addresses and start while busy
        rng = xorshift32(rng); ifm = rng;
        rng = xorshift32(rng); flt = rng;
        apb_read(8'h1C, rdata);
        check_err("unmapped_rd", 1'b1, last_err);
        apb_write(8'h40, 32'd0);
        check_err("unmapped_wr", 1'b1, last_err);
        start_run(2);
        check_err("start_idle", 1'b0, last_err);
        push_pairs(ifm, flt, 1);
        start_run(1);                              // Still waiting on the second pair
        check_err("start_busy", 1'b1, last_err);
        push_pairs(ifm >> 8, flt >> 8, 1);
        check_run("busy_len2", ifm, flt, 2);
        end_test("bus_errors");

        $display("Summary: 6 tests, %0d errors", errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- conv_pe.f
hw/conv_pe_pkg.sv
hw/ifmap_fifo.sv
hw/pe_mac.sv
hw/pe_ctrl.sv
hw/pe_apb_regs.sv
hw/conv_pe_top.sv
verification/conv_pe_checker.sv
verification/conv_pe_tb.sv
